//--- include/rename_settings.svh
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// Instructions per bundle, also the retire width
`define ISSUE_WIDTH 2

// Register counts
`define ARCH_REGS 32
`define PHYS_REGS 64

// Registers not held by the retired table, the free queue depth
`define FREE_REGS (`PHYS_REGS - `ARCH_REGS)

`define ROB_DEPTH 8

// Completion strobes per cycle
`define WB_PORTS 2

`endif

//--- logic/reg_naming_pkg.sv
`include "rename_settings.svh"

package reg_naming_pkg;

    typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(`PHYS_REGS)-1:0] phys_reg_t;

    // Free queue index and fill level
    typedef logic [$clog2(`FREE_REGS)-1:0]   fl_ptr_t;
    typedef logic [$clog2(`FREE_REGS+1)-1:0] fl_count_t;

endpackage

//--- logic/rob_pkg.sv
`include "rename_settings.svh"

package rob_pkg;

    // Slot number in the reorder ring
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_id_t;

    // Occupancy, has to reach ROB_DEPTH itself
    typedef logic [$clog2(`ROB_DEPTH+1)-1:0] rob_count_t;

endpackage

//--- logic/rename_map.sv
`timescale 1ns/100ps
`include "rename_settings.svh"

module rename_map
    import reg_naming_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    accept,
    input  logic [`ISSUE_WIDTH-1:0] slot_valid,
    input  arch_reg_t               arch_rd [`ISSUE_WIDTH],
    input  arch_reg_t               arch_rs1 [`ISSUE_WIDTH],
    input  arch_reg_t               arch_rs2 [`ISSUE_WIDTH],
    input  phys_reg_t               alloc_phys [`ISSUE_WIDTH],
    input  logic [`ISSUE_WIDTH-1:0] commit_release,
    input  arch_reg_t               commit_arch_rd [`ISSUE_WIDTH],
    input  phys_reg_t               commit_phys_rd [`ISSUE_WIDTH],
    output logic [`ISSUE_WIDTH-1:0] need_phys,
    output phys_reg_t               phys_rs1 [`ISSUE_WIDTH],
    output phys_reg_t               phys_rs2 [`ISSUE_WIDTH],
    output phys_reg_t               phys_rd [`ISSUE_WIDTH],
    output phys_reg_t               old_phys [`ISSUE_WIDTH]
);

    // Speculative table follows dispatch, retired table follows commit
    phys_reg_t spec_rat [`ARCH_REGS];
    phys_reg_t retired_rat [`ARCH_REGS];

    // x0 never gets a destination
    always_comb begin
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            need_phys[i] = slot_valid[i] && (arch_rd[i] != '0);
            phys_rd[i] = need_phys[i] ? alloc_phys[i] : '0;
        end
    end

    // Table lookup, then bypass from older slots in the same bundle
    always_comb begin
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            phys_rs1[i] = spec_rat[arch_rs1[i]];
            phys_rs2[i] = spec_rat[arch_rs2[i]];
            old_phys[i] = spec_rat[arch_rd[i]];
            // A later older slot overrides an earlier one
            for (int j = 0; j < i; j++) begin
                if (need_phys[j] && (arch_rs1[i] == arch_rd[j]))
                    phys_rs1[i] = phys_rd[j];
                if (need_phys[j] && (arch_rs2[i] == arch_rd[j]))
                    phys_rs2[i] = phys_rd[j];
                if (need_phys[j] && (arch_rd[i] == arch_rd[j]))
                    old_phys[i] = phys_rd[j];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < `ARCH_REGS; r++)
                spec_rat[r] <= phys_reg_t'(r);
        end else if (flush) begin
            // Drop every speculative mapping
            spec_rat <= retired_rat;
        end else if (accept) begin
            // Highest slot writes last, so it wins on a shared rd
            for (int i = 0; i < `ISSUE_WIDTH; i++) begin
                if (need_phys[i])
                    spec_rat[arch_rd[i]] <= phys_rd[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < `ARCH_REGS; r++)
                retired_rat[r] <= phys_reg_t'(r);
        end else begin
            for (int i = 0; i < `ISSUE_WIDTH; i++) begin
                if (commit_release[i])
                    retired_rat[commit_arch_rd[i]] <= commit_phys_rd[i];
            end
        end
    end

endmodule

//--- logic/free_list.sv
`timescale 1ns/100ps
`include "rename_settings.svh"

module free_list
    import reg_naming_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    accept,
    input  logic [`ISSUE_WIDTH-1:0] need_phys,
    input  logic [`ISSUE_WIDTH-1:0] commit_release,
    input  phys_reg_t               commit_old_phys [`ISSUE_WIDTH],
    output phys_reg_t               alloc_phys [`ISSUE_WIDTH],
    output logic                    has_room
);

    phys_reg_t fl_mem [`FREE_REGS];

    // rewind tracks where head would be if nothing speculative had popped
    fl_ptr_t   head;
    fl_ptr_t   tail;
    fl_ptr_t   rewind;
    fl_count_t count;

    fl_count_t pop_cnt;
    fl_count_t push_cnt;
    fl_ptr_t   pop_idx [`ISSUE_WIDTH];
    fl_ptr_t   push_idx [`ISSUE_WIDTH];

    // Slots with a destination take consecutive entries from the head
    always_comb begin
        pop_cnt = '0;
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            pop_idx[i] = head + fl_ptr_t'(pop_cnt);
            alloc_phys[i] = fl_mem[pop_idx[i]];
            if (accept && need_phys[i])
                pop_cnt = pop_cnt + 1'b1;
        end
    end

    // Released registers pack at the tail in slot order
    always_comb begin
        push_cnt = '0;
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            push_idx[i] = tail + fl_ptr_t'(push_cnt);
            if (commit_release[i])
                push_cnt = push_cnt + 1'b1;
        end
    end

    assign has_room = (count >= fl_count_t'(`ISSUE_WIDTH));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head   <= '0;
            tail   <= '0;
            rewind <= '0;
            count  <= fl_count_t'(`FREE_REGS);
        end else begin
            tail   <= tail + fl_ptr_t'(push_cnt);
            rewind <= rewind + fl_ptr_t'(push_cnt);
            if (flush) begin
                // Everything the retired table does not hold is free again
                head  <= rewind + fl_ptr_t'(push_cnt);
                count <= fl_count_t'(`FREE_REGS);
            end else begin
                head  <= head + fl_ptr_t'(pop_cnt);
                count <= count + push_cnt - pop_cnt;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int e = 0; e < `FREE_REGS; e++)
                fl_mem[e] <= phys_reg_t'(`ARCH_REGS + e);
        end else begin
            for (int i = 0; i < `ISSUE_WIDTH; i++) begin
                if (commit_release[i])
                    fl_mem[push_idx[i]] <= commit_old_phys[i];
            end
        end
    end

    // Back-pressure from the ROB must keep dispatch within the free count
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop_cnt <= count);

endmodule

//--- logic/reorder_buffer.sv
`timescale 1ns/100ps
`include "rename_settings.svh"

module reorder_buffer
    import reg_naming_pkg::*;
    import rob_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic [`ISSUE_WIDTH-1:0] slot_valid,
    input  logic [`ISSUE_WIDTH-1:0] need_phys,
    input  arch_reg_t               arch_rd [`ISSUE_WIDTH],
    input  phys_reg_t               phys_rd [`ISSUE_WIDTH],
    input  phys_reg_t               old_phys [`ISSUE_WIDTH],
    input  logic                    has_room,
    input  logic [`WB_PORTS-1:0]    wb_valid,
    input  rob_id_t                 wb_rob_id [`WB_PORTS],
    output logic                    dispatch_ready,
    output logic                    accept,
    output rob_id_t                 rob_id [`ISSUE_WIDTH],
    output logic [`ISSUE_WIDTH-1:0] commit_valid,
    output logic [`ISSUE_WIDTH-1:0] commit_release,
    output arch_reg_t               commit_arch_rd [`ISSUE_WIDTH],
    output phys_reg_t               commit_phys_rd [`ISSUE_WIDTH],
    output phys_reg_t               commit_old_phys [`ISSUE_WIDTH]
);

    // Entry payload
    arch_reg_t             ent_arch_rd [`ROB_DEPTH];
    phys_reg_t             ent_phys_rd [`ROB_DEPTH];
    phys_reg_t             ent_old_phys [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] ent_has_dest;

    logic [`ROB_DEPTH-1:0] ent_done;
    rob_id_t               head;
    rob_id_t               tail;
    rob_count_t            count;
    rob_count_t            alloc_cnt;
    rob_count_t            retire_cnt;
    logic [`ROB_DEPTH-1:0] occupied;

    // A slot is live when its distance from the head is below the count
    always_comb begin
        rob_id_t offset;
        for (int s = 0; s < `ROB_DEPTH; s++) begin
            offset = rob_id_t'(s) - head;
            occupied[s] = (rob_count_t'(offset) < count);
        end
    end

    assign dispatch_ready = !flush && has_room
                            && ((rob_count_t'(`ROB_DEPTH) - count)
                                >= rob_count_t'(`ISSUE_WIDTH));
    assign accept = dispatch_ready && (|slot_valid);

    always_comb begin
        alloc_cnt = '0;
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            rob_id[i] = tail + rob_id_t'(i);
            if (accept && slot_valid[i])
                alloc_cnt = alloc_cnt + 1'b1;
        end
    end

    // In-order retirement, each slot needs every older one to go too
    always_comb begin
        rob_id_t idx;
        logic    older_ok;
        retire_cnt = '0;
        older_ok = !flush;
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            idx = head + rob_id_t'(i);
            commit_valid[i] = older_ok && occupied[idx] && ent_done[idx];
            commit_release[i] = commit_valid[i] && ent_has_dest[idx];
            commit_arch_rd[i] = ent_arch_rd[idx];
            commit_phys_rd[i] = ent_phys_rd[idx];
            commit_old_phys[i] = ent_old_phys[idx];
            older_ok = commit_valid[i];
            if (commit_valid[i])
                retire_cnt = retire_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            if (accept && slot_valid[i]) begin
                ent_arch_rd[rob_id[i]]  <= arch_rd[i];
                ent_phys_rd[rob_id[i]]  <= phys_rd[i];
                ent_old_phys[rob_id[i]] <= old_phys[i];
                ent_has_dest[rob_id[i]] <= need_phys[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            ent_done <= '0;
        end else if (flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + rob_id_t'(retire_cnt);
            tail  <= tail + rob_id_t'(alloc_cnt);
            count <= count + alloc_cnt - retire_cnt;
            for (int i = 0; i < `ISSUE_WIDTH; i++) begin
                if (accept && slot_valid[i])
                    ent_done[rob_id[i]] <= 1'b0;
            end
            for (int p = 0; p < `WB_PORTS; p++) begin
                if (wb_valid[p])
                    ent_done[wb_rob_id[p]] <= 1'b1;
            end
        end
    end

    // Completion may only come back for an instruction still in flight
    for (genvar p = 0; p < `WB_PORTS; p++) begin : g_wb_check
        a_wb_occupied: assert property (@(posedge clk) disable iff (!rst_n)
            wb_valid[p] |-> occupied[wb_rob_id[p]]);
    end

endmodule

//--- logic/rename_core.sv
`timescale 1ns/100ps
`include "rename_settings.svh"

module rename_core
    import reg_naming_pkg::*;
    import rob_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`ISSUE_WIDTH-1:0] slot_valid,
    input  arch_reg_t               arch_rd [`ISSUE_WIDTH],
    input  arch_reg_t               arch_rs1 [`ISSUE_WIDTH],
    input  arch_reg_t               arch_rs2 [`ISSUE_WIDTH],
    input  logic [`WB_PORTS-1:0]    wb_valid,
    input  rob_id_t                 wb_rob_id [`WB_PORTS],
    input  logic                    flush,
    output logic                    dispatch_ready,
    output phys_reg_t               phys_rs1 [`ISSUE_WIDTH],
    output phys_reg_t               phys_rs2 [`ISSUE_WIDTH],
    output phys_reg_t               phys_rd [`ISSUE_WIDTH],
    output rob_id_t                 rob_id [`ISSUE_WIDTH],
    output logic [`ISSUE_WIDTH-1:0] commit_valid,
    output arch_reg_t               commit_arch_rd [`ISSUE_WIDTH],
    output phys_reg_t               commit_phys_rd [`ISSUE_WIDTH],
    output phys_reg_t               commit_old_phys [`ISSUE_WIDTH]
);

    logic                    accept;
    logic                    has_room;
    logic [`ISSUE_WIDTH-1:0] need_phys;
    logic [`ISSUE_WIDTH-1:0] commit_release;
    phys_reg_t               old_phys [`ISSUE_WIDTH];
    phys_reg_t               alloc_phys [`ISSUE_WIDTH];

    rename_map u_rename_map (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .accept         (accept),
        .slot_valid     (slot_valid),
        .arch_rd        (arch_rd),
        .arch_rs1       (arch_rs1),
        .arch_rs2       (arch_rs2),
        .alloc_phys     (alloc_phys),
        .commit_release (commit_release),
        .commit_arch_rd (commit_arch_rd),
        .commit_phys_rd (commit_phys_rd),
        .need_phys      (need_phys),
        .phys_rs1       (phys_rs1),
        .phys_rs2       (phys_rs2),
        .phys_rd        (phys_rd),
        .old_phys       (old_phys)
    );

    free_list u_free_list (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush           (flush),
        .accept          (accept),
        .need_phys       (need_phys),
        .commit_release  (commit_release),
        .commit_old_phys (commit_old_phys),
        .alloc_phys      (alloc_phys),
        .has_room        (has_room)
    );

    reorder_buffer u_reorder_buffer (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush           (flush),
        .slot_valid      (slot_valid),
        .need_phys       (need_phys),
        .arch_rd         (arch_rd),
        .phys_rd         (phys_rd),
        .old_phys        (old_phys),
        .has_room        (has_room),
        .wb_valid        (wb_valid),
        .wb_rob_id       (wb_rob_id),
        .dispatch_ready  (dispatch_ready),
        .accept          (accept),
        .rob_id          (rob_id),
        .commit_valid    (commit_valid),
        .commit_release  (commit_release),
        .commit_arch_rd  (commit_arch_rd),
        .commit_phys_rd  (commit_phys_rd),
        .commit_old_phys (commit_old_phys)
    );

endmodule

//--- test/rename_tb.sv
`timescale 1ns/100ps
`include "rename_settings.svh"

module rename_tb
    import reg_naming_pkg::*;
    import rob_pkg::*;
();

    // Roughly twice the length of all tests together
    localparam int CYCLE_LIMIT = 4000;

    logic                    clk;
    logic                    rst_n;
    logic [`ISSUE_WIDTH-1:0] slot_valid;
    arch_reg_t               arch_rd [`ISSUE_WIDTH];
    arch_reg_t               arch_rs1 [`ISSUE_WIDTH];
    arch_reg_t               arch_rs2 [`ISSUE_WIDTH];
    logic [`WB_PORTS-1:0]    wb_valid;
    rob_id_t                 wb_rob_id [`WB_PORTS];
    logic                    flush;
    logic                    dispatch_ready;
    phys_reg_t               phys_rs1 [`ISSUE_WIDTH];
    phys_reg_t               phys_rs2 [`ISSUE_WIDTH];
    phys_reg_t               phys_rd [`ISSUE_WIDTH];
    rob_id_t                 rob_id [`ISSUE_WIDTH];
    logic [`ISSUE_WIDTH-1:0] commit_valid;
    arch_reg_t               commit_arch_rd [`ISSUE_WIDTH];
    phys_reg_t               commit_phys_rd [`ISSUE_WIDTH];
    phys_reg_t               commit_old_phys [`ISSUE_WIDTH];

    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int cycle_cnt = 0;
    int unsigned rnd_init;

    // Model tables and free queue
    int m_spec [`ARCH_REGS];
    int m_ret [`ARCH_REGS];
    int m_fq [`FREE_REGS];
    int m_fhead;
    int m_ftail;
    int m_frewind;
    int m_fcount;
    // Model reorder ring
    int m_rarch [`ROB_DEPTH];
    int m_rphys [`ROB_DEPTH];
    int m_rold [`ROB_DEPTH];
    bit m_rdest [`ROB_DEPTH];
    bit m_rdone [`ROB_DEPTH];
    int m_rhead;
    int m_rtail;
    int m_rcount;

    // Expected outputs for the current cycle
    bit                    exp_ready;
    bit                    exp_acc;
    bit [`ISSUE_WIDTH-1:0] exp_cv;
    int exp_carch [`ISSUE_WIDTH];
    int exp_cphys [`ISSUE_WIDTH];
    int exp_cold [`ISSUE_WIDTH];
    int exp_prd [`ISSUE_WIDTH];
    int exp_prs1 [`ISSUE_WIDTH];
    int exp_prs2 [`ISSUE_WIDTH];
    int exp_rid [`ISSUE_WIDTH];

    rename_core u_rename_core (
        .clk             (clk),
        .rst_n           (rst_n),
        .slot_valid      (slot_valid),
        .arch_rd         (arch_rd),
        .arch_rs1        (arch_rs1),
        .arch_rs2        (arch_rs2),
        .wb_valid        (wb_valid),
        .wb_rob_id       (wb_rob_id),
        .flush           (flush),
        .dispatch_ready  (dispatch_ready),
        .phys_rs1        (phys_rs1),
        .phys_rs2        (phys_rs2),
        .phys_rd         (phys_rd),
        .rob_id          (rob_id),
        .commit_valid    (commit_valid),
        .commit_arch_rd  (commit_arch_rd),
        .commit_phys_rd  (commit_phys_rd),
        .commit_old_phys (commit_old_phys)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("ERROR: run stopped after %0d cycles, a test never finished", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic void reset_model();
        for (int r = 0; r < `ARCH_REGS; r++) begin
            m_spec[r] = r;
            m_ret[r] = r;
        end
        for (int e = 0; e < `FREE_REGS; e++)
            m_fq[e] = `ARCH_REGS + e;
        for (int s = 0; s < `ROB_DEPTH; s++)
            m_rdone[s] = 1'b0;
        m_fhead = 0;
        m_ftail = 0;
        m_frewind = 0;
        m_fcount = `FREE_REGS;
        m_rhead = 0;
        m_rtail = 0;
        m_rcount = 0;
    endfunction

    // Expected outputs and next state for the coming edge
    function automatic void step_model();
        int k;
        int slot;
        int ncommit;
        int nvalid;
        int old [`ISSUE_WIDTH];
        bit dest [`ISSUE_WIDTH];
        exp_ready = !flush && (`ROB_DEPTH - m_rcount >= `ISSUE_WIDTH)
                    && (m_fcount >= `ISSUE_WIDTH);
        exp_acc = exp_ready && (slot_valid != '0);
        // Oldest first up to the first entry not done
        ncommit = 0;
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            slot = (m_rhead + i) % `ROB_DEPTH;
            exp_cv[i] = !flush && (ncommit == i) && (i < m_rcount) && m_rdone[slot];
            exp_carch[i] = m_rarch[slot];
            exp_cphys[i] = m_rphys[slot];
            exp_cold[i] = m_rold[slot];
            if (exp_cv[i])
                ncommit++;
        end
        k = 0;
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            dest[i] = slot_valid[i] && (arch_rd[i] != 0);
            exp_prs1[i] = m_spec[arch_rs1[i]];
            exp_prs2[i] = m_spec[arch_rs2[i]];
            old[i] = m_spec[arch_rd[i]];
            for (int j = 0; j < i; j++) begin
                if (dest[j] && arch_rs1[i] == arch_rd[j])
                    exp_prs1[i] = exp_prd[j];
                if (dest[j] && arch_rs2[i] == arch_rd[j])
                    exp_prs2[i] = exp_prd[j];
                if (dest[j] && arch_rd[i] == arch_rd[j])
                    old[i] = exp_prd[j];
            end
            exp_prd[i] = 0;
            if (dest[i]) begin
                exp_prd[i] = m_fq[(m_fhead + k) % `FREE_REGS];
                k++;
            end
            exp_rid[i] = (m_rtail + i) % `ROB_DEPTH;
        end
        if (flush) begin
            m_rhead = 0;
            m_rtail = 0;
            m_rcount = 0;
            m_spec = m_ret;
            m_fhead = m_frewind;
            m_fcount = `FREE_REGS;
        end else begin
            for (int i = 0; i < ncommit; i++) begin
                slot = (m_rhead + i) % `ROB_DEPTH;
                if (m_rdest[slot]) begin
                    m_ret[m_rarch[slot]] = m_rphys[slot];
                    m_fq[m_ftail] = m_rold[slot];
                    m_ftail = (m_ftail + 1) % `FREE_REGS;
                    m_frewind = (m_frewind + 1) % `FREE_REGS;
                    m_fcount++;
                end
            end
            m_rhead = (m_rhead + ncommit) % `ROB_DEPTH;
            m_rcount -= ncommit;
            if (exp_acc) begin
                nvalid = 0;
                for (int i = 0; i < `ISSUE_WIDTH; i++) begin
                    if (slot_valid[i]) begin
                        slot = exp_rid[i];
                        m_rarch[slot] = arch_rd[i];
                        m_rphys[slot] = exp_prd[i];
                        m_rold[slot] = old[i];
                        m_rdest[slot] = dest[i];
                        m_rdone[slot] = 1'b0;
                        if (dest[i])
                            m_spec[arch_rd[i]] = exp_prd[i];
                        nvalid++;
                    end
                end
                m_fhead = (m_fhead + k) % `FREE_REGS;
                m_fcount -= k;
                m_rtail = (m_rtail + nvalid) % `ROB_DEPTH;
                m_rcount += nvalid;
            end
            for (int p = 0; p < `WB_PORTS; p++) begin
                if (wb_valid[p])
                    m_rdone[wb_rob_id[p]] = 1'b1;
            end
        end
    endfunction

    task automatic expect_equal(input string what, input int got, input int want);
        checks++;
        assert (got == want) else begin
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, want);
            errors++;
        end
    endtask

    task automatic compare_outputs();
        expect_equal("dispatch_ready", int'(dispatch_ready), int'(exp_ready));
        expect_equal("commit_valid", int'(commit_valid), int'(exp_cv));
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            if (exp_cv[i]) begin
                expect_equal($sformatf("commit_arch_rd[%0d]", i),
                             int'(commit_arch_rd[i]), exp_carch[i]);
                expect_equal($sformatf("commit_phys_rd[%0d]", i),
                             int'(commit_phys_rd[i]), exp_cphys[i]);
                expect_equal($sformatf("commit_old_phys[%0d]", i),
                             int'(commit_old_phys[i]), exp_cold[i]);
            end
            if (exp_acc && slot_valid[i]) begin
                expect_equal($sformatf("phys_rd[%0d]", i), int'(phys_rd[i]), exp_prd[i]);
                expect_equal($sformatf("phys_rs1[%0d]", i), int'(phys_rs1[i]), exp_prs1[i]);
                expect_equal($sformatf("phys_rs2[%0d]", i), int'(phys_rs2[i]), exp_prs2[i]);
                expect_equal($sformatf("rob_id[%0d]", i), int'(rob_id[i]), exp_rid[i]);
            end
        end
    endtask

    // Outputs have settled half a period after the inputs change
    always @(negedge clk) begin
        if (rst_n) begin
            step_model();
            compare_outputs();
        end
    end

    task automatic tick();
        @(posedge clk);
        #1;
        slot_valid = '0;
        wb_valid = '0;
        flush = 1'b0;
    endtask

    task automatic set_slot(input int s, input int rd, input int rs1, input int rs2);
        slot_valid[s] = 1'b1;
        arch_rd[s] = arch_reg_t'(rd);
        arch_rs1[s] = arch_reg_t'(rs1);
        arch_rs2[s] = arch_reg_t'(rs2);
    endtask

    task automatic send_wb(input int port, input int id);
        wb_valid[port] = 1'b1;
        wb_rob_id[port] = rob_id_t'(id % `ROB_DEPTH);
    endtask

    // Bundle stays on the inputs until the DUT takes it
    task automatic wait_accept(output int first);
        @(negedge clk);
        while (!dispatch_ready)
            @(negedge clk);
        first = int'(rob_id[0]);
    endtask

    // Complete everything in flight and let it retire
    task automatic drain_all();
        int sent;
        int slot;
        tick();
        while (m_rcount != 0) begin
            sent = 0;
            for (int i = 0; i < m_rcount && sent < `WB_PORTS; i++) begin
                slot = (m_rhead + i) % `ROB_DEPTH;
                if (!m_rdone[slot]) begin
                    send_wb(sent, slot);
                    sent++;
                end
            end
            tick();
        end
    endtask

    task automatic random_traffic(input int cycles);
        int slot;
        int pick;
        int nslots;
        for (int c = 0; c < cycles; c++) begin
            tick();
            if ($urandom_range(63) == 0) begin
                flush = 1'b1;
            end else begin
                nslots = $urandom_range(2);
                for (int s = 0; s < nslots; s++)
                    set_slot(s, $urandom_range(15), $urandom_range(15), $urandom_range(15));
                // Slot 1 reading slot 0's result now and then
                if (nslots == 2 && $urandom_range(3) == 0)
                    arch_rs1[1] = arch_rd[0];
                pick = -1;
                for (int p = 0; p < `WB_PORTS; p++) begin
                    if (m_rcount > 0 && $urandom_range(1) == 1) begin
                        slot = (m_rhead + $urandom_range(m_rcount - 1)) % `ROB_DEPTH;
                        if (!m_rdone[slot] && slot != pick) begin
                            send_wb(p, slot);
                            pick = slot;
                        end
                    end
                end
            end
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before)
            $display("test %0d %s: ok", tests_run, name);
        else
            $display("test %0d %s: %0d errors", tests_run, name, errors - errs_before);
    endtask

    initial begin
        int errs;
        int first;
        int p0;
        int p1;
        int r9;
        rnd_init = $urandom(32'hbdd9_4cda);
        rst_n = 1'b0;
        slot_valid = '0;
        wb_valid = '0;
        flush = 1'b0;
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            arch_rd[i] = '0;
            arch_rs1[i] = '0;
            arch_rs2[i] = '0;
        end
        for (int p = 0; p < `WB_PORTS; p++)
            wb_rob_id[p] = '0;
        reset_model();
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        errs = errors;
        tick();
        set_slot(0, 5, 1, 2);
        set_slot(1, 7, 3, 4);
        wait_accept(first);
        expect_equal("first phys_rd[0]", int'(phys_rd[0]), 32);
        expect_equal("first phys_rd[1]", int'(phys_rd[1]), 33);
        expect_equal("first rob_id[0]", int'(rob_id[0]), 0);
        expect_equal("first rob_id[1]", int'(rob_id[1]), 1);
        expect_equal("first phys_rs2[1]", int'(phys_rs2[1]), 4);
        tick();
        send_wb(0, first);
        send_wb(1, first + 1);
        tick();
        @(negedge clk);
        expect_equal("first commit_valid", int'(commit_valid), 3);
        expect_equal("first commit_old_phys[0]", int'(commit_old_phys[0]), 5);
        expect_equal("first commit_old_phys[1]", int'(commit_old_phys[1]), 7);
        drain_all();
        report_test("rename after reset", errs);

        errs = errors;
        tick();
        set_slot(0, 6, 5, 0);
        set_slot(1, 0, 6, 6);
        // Free queue head before this bundle
        p0 = m_fq[m_fhead];
        wait_accept(first);
        expect_equal("bypass phys_rs1[1]", int'(phys_rs1[1]), p0);
        expect_equal("bypass phys_rd[1]", int'(phys_rd[1]), 0);
        tick();
        set_slot(0, 8, 6, 0);
        wait_accept(first);
        expect_equal("after x0 phys_rd[0]", int'(phys_rd[0]), p0 + 1);
        expect_equal("after x0 phys_rs1[0]", int'(phys_rs1[0]), p0);
        drain_all();
        report_test("bundle bypass and x0", errs);

        errs = errors;
        tick();
        set_slot(0, 1, 0, 0);
        set_slot(1, 2, 1, 1);
        wait_accept(first);
        tick();
        set_slot(0, 3, 2, 2);
        set_slot(1, 4, 3, 3);
        wait_accept(p1);
        tick();
        send_wb(0, first + 3);
        send_wb(1, first + 2);
        tick();
        send_wb(0, first + 1);
        @(negedge clk);
        expect_equal("young done commit_valid", int'(commit_valid), 0);
        tick();
        send_wb(0, first);
        @(negedge clk);
        expect_equal("oldest pending commit_valid", int'(commit_valid), 0);
        tick();
        @(negedge clk);
        expect_equal("in order commit_valid", int'(commit_valid), 3);
        expect_equal("in order commit_arch_rd[0]", int'(commit_arch_rd[0]), 1);
        tick();
        @(negedge clk);
        expect_equal("in order commit_valid", int'(commit_valid), 3);
        expect_equal("in order commit_arch_rd[1]", int'(commit_arch_rd[1]), 4);
        drain_all();
        report_test("out of order completion", errs);

        errs = errors;
        for (int b = 0; b < 4; b++) begin
            tick();
            set_slot(0, 11 + 2 * b, 1, 2);
            set_slot(1, 12 + 2 * b, 3, 4);
            wait_accept(p1);
            if (b == 0)
                first = p1;
        end
        tick();
        set_slot(0, 20, 11, 12);
        set_slot(1, 21, 13, 14);
        @(negedge clk);
        expect_equal("full dispatch_ready", int'(dispatch_ready), 0);
        tick();
        set_slot(0, 20, 11, 12);
        set_slot(1, 21, 13, 14);
        send_wb(0, first);
        send_wb(1, first + 1);
        @(negedge clk);
        expect_equal("full dispatch_ready", int'(dispatch_ready), 0);
        tick();
        set_slot(0, 20, 11, 12);
        set_slot(1, 21, 13, 14);
        @(negedge clk);
        expect_equal("retiring dispatch_ready", int'(dispatch_ready), 0);
        tick();
        set_slot(0, 20, 11, 12);
        set_slot(1, 21, 13, 14);
        wait_accept(p1);
        drain_all();
        report_test("back-pressure when full", errs);

        errs = errors;
        tick();
        set_slot(0, 9, 0, 0);
        set_slot(1, 10, 9, 0);
        // The two registers this bundle takes from the free queue
        p0 = m_fq[m_fhead];
        p1 = m_fq[(m_fhead + 1) % `FREE_REGS];
        wait_accept(first);
        tick();
        flush = 1'b1;
        r9 = m_ret[9];
        @(negedge clk);
        expect_equal("flush dispatch_ready", int'(dispatch_ready), 0);
        tick();
        set_slot(0, 11, 9, 10);
        set_slot(1, 12, 0, 0);
        wait_accept(first);
        expect_equal("reuse phys_rd[0]", int'(phys_rd[0]), p0);
        expect_equal("reuse phys_rd[1]", int'(phys_rd[1]), p1);
        expect_equal("restored phys_rs1[0]", int'(phys_rs1[0]), r9);
        expect_equal("restart rob_id[0]", int'(rob_id[0]), 0);
        drain_all();
        report_test("flush recovery", errs);

        errs = errors;
        random_traffic(1500);
        drain_all();
        report_test("random traffic", errs);

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- build.f
+incdir+include
logic/reg_naming_pkg.sv
logic/rob_pkg.sv
logic/rename_map.sv
logic/free_list.sv
logic/reorder_buffer.sv
logic/rename_core.sv
test/rename_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the rename core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module rename_tb -f build.f -o rename_sim \
    && ./obj_dir/rename_sim | tee sim.log \
    && grep -qx "PASS: all tests" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
